/* Makefile */
SIM      := verilator
TOP      := tb_bbox_top
FILELIST := filelist.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -j 0 -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+verif
src/bbox_pkg.sv
src/bbox_face_cull.sv
src/bbox_extent.sv
src/bbox_snap_clip.sv
src/bbox_stage_pipe.sv
src/bbox_top.sv
verif/tb_bbox_top.sv

/* src/bbox_extent.sv */
`default_nettype none

module bbox_extent (
    input  bbox_pkg::tri_t tri_in,
    output bbox_pkg::box_t raw_box
);
    import bbox_pkg::*;

    // Signed minimum of three, lower index wins a tie
    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (b < a) ? b : a; // Tie keeps a
        return (c < m) ? c : m;
    endfunction

    // Signed maximum of three, lower index wins a tie
    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (b > a) ? b : a; // Tie keeps a
        return (c > m) ? c : m;
    endfunction

    // Lower left from the per-axis minimum
    assign raw_box.ll.x = min3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
    assign raw_box.ll.y = min3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);

    // Upper right from the per-axis maximum
    assign raw_box.ur.x = max3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
    assign raw_box.ur.y = max3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);

endmodule

`default_nettype wire

/* src/bbox_face_cull.sv */
`default_nettype none

module bbox_face_cull (
    input  bbox_pkg::tri_t tri_in,
    output logic           back_face
);
    import bbox_pkg::*;

    // One extra bit so vertex differences never wrap
    localparam int EDGE_W  = COORD_W + 1;
    // Product of two edges plus one bit for the subtraction
    localparam int CROSS_W = 2 * EDGE_W + 1;

    logic signed [EDGE_W-1:0]  e0_x; // Edge v0 -> v1
    logic signed [EDGE_W-1:0]  e0_y;
    logic signed [EDGE_W-1:0]  e1_x; // Edge v1 -> v2
    logic signed [EDGE_W-1:0]  e1_y;
    logic signed [CROSS_W-1:0] cross_z; // Z of e0 x e1, exact

    assign e0_x = tri_in.v1.x - tri_in.v0.x;
    assign e0_y = tri_in.v1.y - tri_in.v0.y;
    assign e1_x = tri_in.v2.x - tri_in.v1.x;
    assign e1_y = tri_in.v2.y - tri_in.v1.y;

    // Sign of the cross product gives the winding
    assign cross_z = e0_x * e1_y - e1_x * e0_y;

    // Strictly positive means back-facing, degenerate ones pass
    assign back_face = (cross_z > 0);

endmodule

`default_nettype wire

/* src/bbox_pkg.sv */
`default_nettype none

package bbox_pkg;

    // Fixed-point format of all screen coordinates
    localparam int COORD_W = 24; // Total bits, two's complement
    localparam int FRAC_W  = 10; // Fraction bits at the bottom

    // Signed coordinate, 14 integer bits over 10 fraction bits
    typedef logic signed [COORD_W-1:0] coord_t;

    // Log2 of samples per pixel side
    // 0 is 1x, 1 is 4x, 2 is 16x, 3 is 64x
    // Also the number of top fraction bits kept on flooring
    typedef logic [1:0] msaa_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t; // 48 bits

    typedef struct packed {
        point_t v0;
        point_t v1;
        point_t v2;
    } tri_t; // 144 bits

    typedef struct packed {
        point_t ll; // Lower left corner
        point_t ur; // Upper right corner
    } box_t; // 96 bits

    // Per-triangle configuration, sampled with its triangle
    typedef struct packed {
        point_t screen; // Width and height, same format as vertices
        msaa_t  msaa;
    } cfg_t; // 50 bits

endpackage

`default_nettype wire

/* src/bbox_snap_clip.sv */
`default_nettype none

module bbox_snap_clip (
    input  bbox_pkg::box_t raw_box,
    input  bbox_pkg::cfg_t cfg,
    input  logic           back_face,
    input  logic           tri_valid,
    output bbox_pkg::box_t clip_box,
    output logic           keep
);
    import bbox_pkg::*;

    localparam int INT_W = COORD_W - FRAC_W; // Integer bits, always kept

    logic [FRAC_W-1:0] frac_mask; // Surviving fraction bits
    coord_t            grid_mask; // Whole-coordinate floor mask
    box_t              snap_box;  // Box floored to the sample grid
    logic              ll_on_screen;
    logic              ur_on_screen;

    // Top msaa fraction bits set, e.g. code 2 gives 11_0000_0000
    assign frac_mask = ~({FRAC_W{1'b1}} >> cfg.msaa);
    assign grid_mask = {{INT_W{1'b1}}, frac_mask};

    // Floor by masking, which rounds toward minus infinity
    assign snap_box.ll.x = raw_box.ll.x & grid_mask;
    assign snap_box.ll.y = raw_box.ll.y & grid_mask;
    assign snap_box.ur.x = raw_box.ur.x & grid_mask;
    assign snap_box.ur.y = raw_box.ur.y & grid_mask;

    // Lower left clamps to the origin, tested on the raw value
    assign clip_box.ll.x = (raw_box.ll.x < 0) ? '0 : snap_box.ll.x;
    assign clip_box.ll.y = (raw_box.ll.y < 0) ? '0 : snap_box.ll.y;

    // Upper right clamps to the screen edge
    assign clip_box.ur.x = (raw_box.ur.x > cfg.screen.x) ? cfg.screen.x : snap_box.ur.x;
    assign clip_box.ur.y = (raw_box.ur.y > cfg.screen.y) ? cfg.screen.y : snap_box.ur.y;

    // Box must start inside the screen
    assign ll_on_screen = (clip_box.ll.x < cfg.screen.x) && (clip_box.ll.y < cfg.screen.y);

    // and end right of and above the origin
    assign ur_on_screen = (clip_box.ur.x > 0) && (clip_box.ur.y > 0);

    // Drop invalid, back-facing and off-screen triangles
    assign keep = tri_valid && !back_face && ll_on_screen && ur_on_screen;

endmodule

`default_nettype wire

/* src/bbox_stage_pipe.sv */
`default_nettype none

module bbox_stage_pipe #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           hold,    // Freezes every stage
    input  bbox_pkg::tri_t tri_d,
    input  bbox_pkg::box_t box_d,
    input  logic           valid_d,
    output bbox_pkg::tri_t tri_q,
    output bbox_pkg::box_t box_q,
    output logic           valid_q
);
    import bbox_pkg::*;

    tri_t tri_r   [PIPE_DEPTH]; // Index 0 is the capture stage
    box_t box_r   [PIPE_DEPTH];
    logic valid_r [PIPE_DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                tri_r[i]   <= '0;
                box_r[i]   <= '0;
                valid_r[i] <= 1'b0;
            end
        end else if (!hold) begin // Advance one stage
            tri_r[0]   <= tri_d;
            box_r[0]   <= box_d;
            valid_r[0] <= valid_d;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                tri_r[i]   <= tri_r[i-1];
                box_r[i]   <= box_r[i-1];
                valid_r[i] <= valid_r[i-1];
            end
        end
    end

    // Last stage drives the outputs
    assign tri_q   = tri_r[PIPE_DEPTH-1];
    assign box_q   = box_r[PIPE_DEPTH-1];
    assign valid_q = valid_r[PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* src/bbox_top.sv */
`default_nettype none

module bbox_top #(
    parameter int PIPE_DEPTH = 3 // Register stages from input to output
) (
    input  logic           clk,
    input  logic           arst_n,

    // Upstream triangle
    input  bbox_pkg::tri_t tri_in,
    input  logic           in_valid,
    input  bbox_pkg::cfg_t cfg,      // Sampled with its triangle

    // Stall from downstream
    input  logic           hold,

    // Triangle and its box, PIPE_DEPTH enabled cycles later
    output bbox_pkg::tri_t tri_out,
    output bbox_pkg::box_t box_out,
    output logic           out_valid
);
    import bbox_pkg::*;

    logic back_face; // Winding of the incoming triangle
    box_t raw_box;   // Vertex min and max
    box_t clip_box;  // Snapped and clamped box
    logic keep;      // Triangle survives culling

    bbox_face_cull u_face_cull (
        .tri_in    (tri_in),
        .back_face (back_face)
    );

    bbox_extent u_extent (
        .tri_in  (tri_in),
        .raw_box (raw_box)
    );

    bbox_snap_clip u_snap_clip (
        .raw_box   (raw_box),
        .cfg       (cfg),
        .back_face (back_face),
        .tri_valid (in_valid),
        .clip_box  (clip_box),
        .keep      (keep)
    );

    // All combinational work sits ahead of the register chain
    bbox_stage_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_stage_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .hold    (hold),
        .tri_d   (tri_in),
        .box_d   (clip_box),
        .valid_d (keep),
        .tri_q   (tri_out),
        .box_q   (box_out),
        .valid_q (out_valid)
    );

endmodule

`default_nettype wire

/* verif/bbox_model.svh */
`ifndef BBOX_MODEL_SVH
`define BBOX_MODEL_SVH

// One expected item as it should leave the register chain
typedef struct packed {
    logic  valid;
    msaa_t msaa;    // Grid of this item, used by the fraction check
    tri_t  tri_exp;
    box_t  box_exp;
} expect_t;

// 32-bit xorshift step with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// Floor onto a grid of 2^(FRAC_W - msaa) LSBs, toward minus infinity
function automatic longint floor_to_grid(input longint v, input int msaa);
    longint step;
    longint q;
    step = longint'(1) << (FRAC_W - msaa);
    q = v / step; // Truncates toward zero
    if ((v % step != 0) && (v < 0))
        q = q - 1;  // One grid step down for negative remainders
    return q * step;
endfunction

// Fraction bits that flooring must leave clear
function automatic box_t frac_low_mask(input msaa_t msaa);
    coord_t low;
    box_t   mask;
    low = coord_t'((longint'(1) << (FRAC_W - int'(msaa))) - 1);
    mask.ll.x = low;
    mask.ll.y = low;
    mask.ur.x = low;
    mask.ur.y = low;
    return mask;
endfunction

// Expected output item for one captured triangle
function automatic expect_t model_bbox(input tri_t t, input cfg_t c, input logic item_valid);
    longint  vx [3];
    longint  vy [3];
    longint  cross_z;
    longint  lo_x;
    longint  lo_y;
    longint  hi_x;
    longint  hi_y;
    longint  scr_x;
    longint  scr_y;
    expect_t e;
    vx[0] = longint'(t.v0.x);
    vy[0] = longint'(t.v0.y);
    vx[1] = longint'(t.v1.x);
    vy[1] = longint'(t.v1.y);
    vx[2] = longint'(t.v2.x);
    vy[2] = longint'(t.v2.y);
    // Winding from (v1 - v0) x (v2 - v1)
    cross_z = (vx[1] - vx[0]) * (vy[2] - vy[1]) - (vx[2] - vx[1]) * (vy[1] - vy[0]);
    lo_x = vx[0];
    lo_y = vy[0];
    hi_x = vx[0];
    hi_y = vy[0];
    for (int i = 1; i < 3; i++) begin
        if (vx[i] < lo_x) lo_x = vx[i];
        if (vy[i] < lo_y) lo_y = vy[i];
        if (vx[i] > hi_x) hi_x = vx[i];
        if (vy[i] > hi_y) hi_y = vy[i];
    end
    scr_x = longint'(c.screen.x);
    scr_y = longint'(c.screen.y);
    // Clamp decisions look at the raw extent
    lo_x = (lo_x < 0) ? 0 : floor_to_grid(lo_x, int'(c.msaa));
    lo_y = (lo_y < 0) ? 0 : floor_to_grid(lo_y, int'(c.msaa));
    hi_x = (hi_x > scr_x) ? scr_x : floor_to_grid(hi_x, int'(c.msaa));
    hi_y = (hi_y > scr_y) ? scr_y : floor_to_grid(hi_y, int'(c.msaa));
    e.valid = item_valid && (cross_z <= 0) && (lo_x < scr_x) && (lo_y < scr_y)
              && (hi_x > 0) && (hi_y > 0);
    e.msaa = c.msaa;
    e.tri_exp = t; // Triangle passes through untouched
    e.box_exp.ll.x = coord_t'(lo_x);
    e.box_exp.ll.y = coord_t'(lo_y);
    e.box_exp.ur.x = coord_t'(hi_x);
    e.box_exp.ur.y = coord_t'(hi_y);
    return e;
endfunction

`endif

/* verif/tb_bbox_top.sv */
`default_nettype none

module tb_bbox_top;
    timeunit 1ns;
    timeprecision 1ps;

    import bbox_pkg::*;

    localparam int PIPE_DEPTH     = 3;
    localparam int NUM_CYCLES     = 3000; // Random stimulus cycles
    localparam int RESET_CYCLES   = 3;
    localparam int MARGIN_CYCLES  = 994;  // Slack on top of stimulus, reset and drain
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + PIPE_DEPTH + MARGIN_CYCLES;
    localparam logic [31:0] SEED  = 32'hd9eb_7584;

    logic clk;
    logic arst_n;
    tri_t tri_in;
    logic in_valid;
    cfg_t cfg;
    logic hold;
    tri_t tri_out;
    box_t box_out;
    logic out_valid;

    `include "bbox_model.svh"

    logic [31:0] rng_state;
    expect_t     pipe_model [$]; // Software register chain, index 0 is the oldest
    tri_t        last_tri;       // Outputs at the previous check
    box_t        last_box;
    logic        last_valid;
    int          cycle_count  = 0;
    int          kept_count   = 0;
    int          culled_count = 0; // Valid input dropped by the keep rule

    bbox_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .tri_in    (tri_in),
        .in_valid  (in_valid),
        .cfg       (cfg),
        .hold      (hold),
        .tri_out   (tri_out),
        .box_out   (box_out),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Integer part in [0, size) inside the screen, else in [-size, 2*size)
    function automatic coord_t rand_coord(input int size, input logic on_screen);
        logic [31:0] r;
        int          ip;
        r = next_rand();
        if (on_screen)
            ip = int'(r[25:10]) % size;
        else
            ip = int'(r[25:10]) % (3 * size) - size;
        return coord_t'((longint'(ip) << FRAC_W) + longint'(r[9:0])); // Random fraction
    endfunction

    task automatic check_value(input string name, input logic [143:0] got,
                               input logic [143:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Runs at the falling edge, outputs settled since the rising edge
    task automatic check_outputs();
        expect_t e;
        e = pipe_model[0];
        if (hold) begin // Last edge was stalled
            check_value("tri_out", 144'(tri_out), 144'(last_tri));
            check_value("box_out", 144'(box_out), 144'(last_box));
            check_value("out_valid", 144'(out_valid), 144'(last_valid));
        end
        check_value("out_valid", 144'(out_valid), 144'(e.valid));
        if (out_valid) begin
            check_value("box_out", 144'(box_out), 144'(e.box_exp));
            check_value("tri_out", 144'(tri_out), 144'(e.tri_exp));
            check_value("box_out below grid", 144'(box_out & frac_low_mask(e.msaa)), '0);
        end
        last_tri   = tri_out;
        last_box   = box_out;
        last_valid = out_valid;
    endtask

    // New inputs for the next rising edge, model follows hold
    task automatic drive_inputs(input logic drain);
        logic [31:0] r;
        int          w;
        int          h;
        logic        on_screen;
        expect_t     exp_item;
        r = next_rand();
        w = 256 << r[1:0]; // Screens 256 to 2048 wide, 4:3
        h = (w * 3) / 4;
        cfg.screen.x = coord_t'(longint'(w) << FRAC_W);
        cfg.screen.y = coord_t'(longint'(h) << FRAC_W);
        cfg.msaa     = r[3:2];
        on_screen    = r[4];  // Half the triangles stay on screen
        in_valid     = !drain && (r[15:8] < 8'd230);
        hold         = !drain && (r[23:16] < 8'd51);
        tri_in.v0.x  = rand_coord(w, on_screen);
        tri_in.v0.y  = rand_coord(h, on_screen);
        tri_in.v1.x  = rand_coord(w, on_screen);
        tri_in.v1.y  = rand_coord(h, on_screen);
        tri_in.v2.x  = rand_coord(w, on_screen);
        tri_in.v2.y  = rand_coord(h, on_screen);
        if (!hold) begin
            exp_item = model_bbox(tri_in, cfg, in_valid);
            pipe_model.push_back(exp_item);
            void'(pipe_model.pop_front());
            if (exp_item.valid)
                kept_count++;
            else if (in_valid)
                culled_count++;
        end
    endtask

    initial begin
        rng_state  = SEED;
        arst_n     = 1'b0;
        hold       = 1'b0;
        in_valid   = 1'b0;
        tri_in     = '0;
        cfg        = '0;
        last_tri   = '0;
        last_box   = '0;
        last_valid = 1'b0;
        for (int i = 0; i < PIPE_DEPTH; i++)
            pipe_model.push_back('0); // Reset contents of the chain
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        drive_inputs(1'b0);
        // Last PIPE_DEPTH cycles flush the chain with hold low
        for (int i = 0; i < NUM_CYCLES + PIPE_DEPTH; i++) begin
            @(negedge clk);
            check_outputs();
            drive_inputs(i >= NUM_CYCLES);
        end
        @(negedge clk);
        check_outputs();
        if (kept_count == 0 || culled_count == 0) begin
            $display("ERROR: stimulus never produced both kept and culled triangles");
            $display("TEST FAIL");
            $fatal(1, "Stimulus too narrow");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
